// File: lumi_credit_ctrl.sv
// Remote credit inputs are absolute line counts and wrap modulo 2^16
`timescale 1ns/1ns
`include "lumi_defines.svh"

module lumi_credit_ctrl
  (
   input                           clk,
   input                           nreset,
   input lumi_pkg::lumi_cfg_t      cfg,
   input lumi_pkg::lumi_pkt_info_t req_info,
   input lumi_pkg::lumi_pkt_info_t resp_info,
   input [`LUMI_CRW-1:0]           rmt_crdt_req,   // advertised by far side
   input [`LUMI_CRW-1:0]           rmt_crdt_resp,
   input [`LUMI_CRW-1:0]           loc_crdt_req,   // sent to far side
   input [`LUMI_CRW-1:0]           loc_crdt_resp,
   input                           crdt_load,      // message taken by shifter
   input                           line_taken,
   input [1:0]                     line_chan,      // {resp, req}
   output logic                    req_ok,
   output logic                    resp_ok,
   output logic                    crdt_pend,
   output lumi_pkg::umi_pkt_t      crdt_pkt
   );

   logic [`LUMI_CRW-1:0] sent_req;     // lines sent on request
   logic [`LUMI_CRW-1:0] sent_resp;
   logic [`LUMI_CRW-1:0] avail_req;
   logic [`LUMI_CRW-1:0] avail_resp;
   logic [15:0]          intrvl_cnt;
   logic                 intrvl_hit;
   logic [1:0]           pend;         // bit 0 resp msg, bit 1 req msg

   //##############################
   // Credit accounting
   //##############################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         sent_req  <= '0;
         sent_resp <= '0;
      end
      else if (line_taken)
      begin
         sent_req  <= sent_req  + `LUMI_CRW'(line_chan[0]);
         sent_resp <= sent_resp + `LUMI_CRW'(line_chan[1]);  // Msg lines not counted
      end
   end

   assign avail_req  = rmt_crdt_req  - sent_req;   // wraps
   assign avail_resp = rmt_crdt_resp - sent_resp;

   assign req_ok  = avail_req  >= req_info.lines;
   assign resp_ok = avail_resp >= resp_info.lines;

   //##############################
   // Update message timing
   //##############################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         intrvl_cnt <= '0;
      else if (cfg.crdt_en)
         intrvl_cnt <= intrvl_hit ? 16'd0 : intrvl_cnt + 16'd1;
   end

   assign intrvl_hit = cfg.crdt_en & (intrvl_cnt == cfg.intrvl);

   // Response message goes out first, then request
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         pend <= 2'b00;
      else if (crdt_load)
         pend <= pend << 1;                 // 01 -> 10 -> 00
      else if (intrvl_hit && pend == 2'b00)
         pend <= 2'b01;                     // Only when idle, keeps pairs whole
   end

   assign crdt_pend = |pend;

   // Message word in the credit view, no addresses or data
   always_comb
   begin
      crdt_pkt                     = '0;
      crdt_pkt.cmd.crdt.link_code  = `LUMI_LINK_CODE;
      crdt_pkt.cmd.crdt.chan       = pend[0] ? 4'h1 : 4'h0;
      crdt_pkt.cmd.crdt.credit     = pend[0] ? loc_crdt_resp : loc_crdt_req;
   end

endmodule

// File: lumi_defines.svh
// Fixed widths only; changing packet sizes also needs matching lumi_pkg field widths
`ifndef LUMI_DEFINES_SVH
`define LUMI_DEFINES_SVH

// Field widths
`define LUMI_CW        32   // command word
`define LUMI_AW        32   // dst/src address
`define LUMI_DW        64   // data payload
`define LUMI_IOW       64   // phy line
`define LUMI_CRW       16   // credit counters

// Packet sizes in bytes
`define LUMI_HDR_BYTES 12   // cmd + dstaddr + srcaddr
`define LUMI_PKT_BYTES 20   // header + full data

// Opcodes with their own size class
`define LUMI_OP_INVALID 5'd0
`define LUMI_OP_READ    5'd1
`define LUMI_OP_WRRESP  5'd4
`define LUMI_OP_LINK    5'd15

`define LUMI_LINK_CODE  8'h2F   // low byte of a credit message

// Register map
`define LUMI_REG_CTRL   16'd0
`define LUMI_REG_IOW    16'd1
`define LUMI_REG_INTRVL 16'd2

`endif

// File: lumi_pkg.sv
// Field order fixed so that byte 0 of a packet is the low command byte
`include "lumi_defines.svh"

package lumi_pkg;

   //##############################
   // Command word views
   //##############################

   // Normal UMI command, opcode in the low bits
   typedef struct packed {
      logic [15:0] user;
      logic [7:0]  len;    // beats minus one
      logic [2:0]  size;   // log2 of bytes per beat
      logic [4:0]  opcode;
   } umi_cmd_t;

   // Credit update message
   typedef struct packed {
      logic [15:0] credit;     // local credit count
      logic [3:0]  chan;       // 1 response, 0 request
      logic [3:0]  rsvd;
      logic [7:0]  link_code;
   } lumi_crdt_t;

   // Same word, decoded either way
   typedef union packed {
      umi_cmd_t   umi;
      lumi_crdt_t crdt;
   } lumi_cmd_u;

   // Full packet, cmd sits in the LSBs
   typedef struct packed {
      logic [`LUMI_DW-1:0] data;
      logic [`LUMI_AW-1:0] srcaddr;
      logic [`LUMI_AW-1:0] dstaddr;
      lumi_cmd_u           cmd;
   } umi_pkt_t;

   // Sizer result per channel
   typedef struct packed {
      logic [`LUMI_PKT_BYTES-1:0] byte_mask;  // contiguous from bit 0
      logic [`LUMI_CRW-1:0]       lines;      // credit lines needed
   } lumi_pkt_info_t;

   // Configuration
   typedef struct packed {
      logic        en;
      logic        crdt_en;
      logic [1:0]  iowidth;   // log2 of bytes per line
      logic [15:0] intrvl;    // credit update interval
   } lumi_cfg_t;

endpackage

// File: lumi_pkt_sizer.sv
// Only four opcode classes are decoded; data bytes are capped at 8 per packet
`timescale 1ns/1ns
`include "lumi_defines.svh"

module lumi_pkt_sizer
  (
   input lumi_pkg::lumi_cmd_u       cmd,
   input [1:0]                      iowidth,   // log2 bytes per line
   output lumi_pkg::lumi_pkt_info_t info
   );

   logic [15:0] data_bytes;   // (len+1) << size, uncapped
   logic [3:0]  data_cap;     // at most one data word
   logic [4:0]  pkt_bytes;    // 4..20
   logic [5:0]  pkt_round;    // bytes plus line width minus one

   // Payload length from the UMI view
   assign data_bytes = ({8'h00, cmd.umi.len} + 16'd1) << cmd.umi.size;
   assign data_cap   = (data_bytes > 16'd8) ? 4'd8 : data_bytes[3:0];

   //##############################
   // Opcode class
   //##############################

   always_comb
   begin
      case (cmd.umi.opcode)
         `LUMI_OP_INVALID,
         `LUMI_OP_LINK:   pkt_bytes = 5'(`LUMI_CW/8);       // Command only
         `LUMI_OP_READ,
         `LUMI_OP_WRRESP: pkt_bytes = 5'(`LUMI_HDR_BYTES);  // Header only
         default:         pkt_bytes = 5'(`LUMI_HDR_BYTES) + {1'b0, data_cap};
      endcase
   end

   // Contiguous mask from byte 0
   assign info.byte_mask = ~({`LUMI_PKT_BYTES{1'b1}} << pkt_bytes);

   // Round up to whole lines
   assign pkt_round  = {1'b0, pkt_bytes} + (6'd1 << iowidth) - 6'd1;
   assign info.lines = `LUMI_CRW'(pkt_round >> iowidth);

endmodule

// File: lumi_tb_clock.sv
// Free-running clock from time zero; period fixed by parameter, no enable
`timescale 1ns/1ns

module lumi_tb_clock
  #(parameter int PERIOD = 100)   // ns
  (
   output logic clk
   );

   initial
   begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;   // 50% duty
   end

endmodule

// File: lumi_tx.sv
// Single clock; phy_ready is a plain level from the receiver, no output FIFO
`timescale 1ns/1ns
`include "lumi_defines.svh"

module lumi_tx
  (
   input                        clk,
   input                        nreset,
   // Request channel
   input                        req_valid,
   input lumi_pkg::umi_pkt_t    req_pkt,
   output logic                 req_ready,
   // Response channel
   input                        resp_valid,
   input lumi_pkg::umi_pkt_t    resp_pkt,
   output logic                 resp_ready,
   // Registers
   input                        reg_wr,
   input [15:0]                 reg_addr,
   input [15:0]                 reg_wdata,
   // Credits
   input [`LUMI_CRW-1:0]        rmt_crdt_req,
   input [`LUMI_CRW-1:0]        rmt_crdt_resp,
   input [`LUMI_CRW-1:0]        loc_crdt_req,
   input [`LUMI_CRW-1:0]        loc_crdt_resp,
   // Phy
   output logic [`LUMI_IOW-1:0] phy_txdata,
   output logic                 phy_txvld,
   input                        phy_ready
   );

   lumi_pkg::lumi_cfg_t      cfg;
   lumi_pkg::lumi_pkt_info_t req_info;
   lumi_pkg::lumi_pkt_info_t resp_info;
   lumi_pkg::umi_pkt_t       crdt_pkt;
   lumi_pkg::umi_pkt_t       load_pkt;
   logic                     req_ok;
   logic                     resp_ok;
   logic                     crdt_pend;
   logic                     crdt_load;
   logic                     load;
   logic [`LUMI_PKT_BYTES-1:0] load_mask;
   logic [1:0]               load_chan;
   logic                     free;
   logic                     line_taken;
   logic [1:0]               line_chan;

   lumi_tx_regs regs_i (.clk, .nreset, .reg_wr, .reg_addr, .reg_wdata, .cfg);

   // One sizer per channel
   lumi_pkt_sizer sizer_req  (.cmd(req_pkt.cmd),  .iowidth(cfg.iowidth), .info(req_info));
   lumi_pkt_sizer sizer_resp (.cmd(resp_pkt.cmd), .iowidth(cfg.iowidth), .info(resp_info));

   lumi_credit_ctrl credit_i
     (.clk, .nreset, .cfg, .req_info, .resp_info,
      .rmt_crdt_req, .rmt_crdt_resp, .loc_crdt_req, .loc_crdt_resp,
      .crdt_load, .line_taken, .line_chan,
      .req_ok, .resp_ok, .crdt_pend, .crdt_pkt);

   lumi_tx_arbiter arbiter_i
     (.cfg, .req_valid, .req_pkt, .resp_valid, .resp_pkt, .req_info, .resp_info,
      .req_ok, .resp_ok, .crdt_pend, .crdt_pkt, .free, .phy_ready,
      .req_ready, .resp_ready, .crdt_load, .load, .load_pkt, .load_mask, .load_chan);

   lumi_tx_shifter shifter_i
     (.clk, .nreset, .cfg, .load, .load_pkt, .load_mask, .load_chan, .phy_ready,
      .free, .line_taken, .line_chan, .phy_txdata, .phy_txvld);

endmodule

// File: lumi_tx_arbiter.sv
// Purely combinational; valid must stay stable until ready is seen
`timescale 1ns/1ns
`include "lumi_defines.svh"

module lumi_tx_arbiter
  (
   input lumi_pkg::lumi_cfg_t        cfg,
   input                             req_valid,
   input lumi_pkg::umi_pkt_t         req_pkt,
   input                             resp_valid,
   input lumi_pkg::umi_pkt_t         resp_pkt,
   input lumi_pkg::lumi_pkt_info_t   req_info,
   input lumi_pkg::lumi_pkt_info_t   resp_info,
   input                             req_ok,      // enough credit
   input                             resp_ok,
   input                             crdt_pend,
   input lumi_pkg::umi_pkt_t         crdt_pkt,
   input                             free,        // shifter can take a packet
   input                             phy_ready,
   output logic                      req_ready,
   output logic                      resp_ready,
   output logic                      crdt_load,
   output logic                      load,
   output lumi_pkg::umi_pkt_t        load_pkt,
   output logic [`LUMI_PKT_BYTES-1:0] load_mask,
   output logic [1:0]                load_chan    // {resp, req}, 00 for msg
   );

   logic go;          // shifter slot open this cycle
   logic req_gate;
   logic resp_gate;
   logic req_sel;
   logic resp_sel;

   assign go = free & cfg.en & phy_ready;

   // Channel gating, a pending message blocks both
   assign req_gate  = req_valid  & req_ok  & ~crdt_pend;
   assign resp_gate = resp_valid & resp_ok & ~crdt_pend;

   //##############################
   // Priority select
   //##############################

   assign crdt_load = go & crdt_pend;                  // Message first
   assign resp_sel  = go & resp_gate;                  // then response
   assign req_sel   = go & req_gate & ~resp_gate;      // then request

   assign resp_ready = resp_sel;
   assign req_ready  = req_sel;

   assign load      = crdt_load | resp_sel | req_sel;
   assign load_chan = {resp_sel, req_sel};

   always_comb
   begin
      if (crdt_pend)
      begin
         load_pkt  = crdt_pkt;
         load_mask = ~({`LUMI_PKT_BYTES{1'b1}} << (`LUMI_CW/8));  // Cmd word only
      end
      else if (resp_gate)
      begin
         load_pkt  = resp_pkt;
         load_mask = resp_info.byte_mask;
      end
      else
      begin
         load_pkt  = req_pkt;
         load_mask = req_info.byte_mask;
      end
   end

endmodule

// File: lumi_tx_regs.sv
// Write-only registers; unmapped addresses are ignored and nothing reads back
`timescale 1ns/1ns
`include "lumi_defines.svh"

module lumi_tx_regs
  (
   input                     clk,
   input                     nreset,
   input                     reg_wr,      // write strobe
   input [15:0]              reg_addr,
   input [15:0]              reg_wdata,
   output lumi_pkg::lumi_cfg_t cfg
   );

   //##############################
   // Register writes
   //##############################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         cfg <= '0;                                 // all off after reset
      end
      else if (reg_wr)
      begin
         case (reg_addr)
            `LUMI_REG_CTRL:
            begin
               cfg.en      <= reg_wdata[0];
               cfg.crdt_en <= reg_wdata[1];
            end
            `LUMI_REG_IOW:    cfg.iowidth <= reg_wdata[1:0];  // 1,2,4,8 bytes
            `LUMI_REG_INTRVL: cfg.intrvl  <= reg_wdata;
            default:          cfg         <= cfg;             // Unmapped
         endcase
      end
   end

endmodule

// File: lumi_tx_shifter.sv
// Lanes above the valid bytes of a line carry stale data and must be ignored
`timescale 1ns/1ns
`include "lumi_defines.svh"

module lumi_tx_shifter
  (
   input                             clk,
   input                             nreset,
   input lumi_pkg::lumi_cfg_t        cfg,
   input                             load,
   input lumi_pkg::umi_pkt_t         load_pkt,
   input [`LUMI_PKT_BYTES-1:0]       load_mask,
   input [1:0]                       load_chan,
   input                             phy_ready,
   output logic                      free,
   output logic                      line_taken,
   output logic [1:0]                line_chan,
   output logic [`LUMI_IOW-1:0]      phy_txdata,
   output logic                      phy_txvld
   );

   logic [`LUMI_PKT_BYTES*8-1:0] sreg;        // packet bytes, LSB first
   logic [`LUMI_PKT_BYTES-1:0]   mask;        // bytes still to send
   logic [`LUMI_PKT_BYTES-1:0]   mask_next;
   logic [1:0]                   chan;        // channel tag of current packet
   logic [3:0]                   step;        // bytes per line
   logic [6:0]                   step_bits;

   assign step      = 4'd1 << cfg.iowidth;
   assign step_bits = {step, 3'b000};
   assign mask_next = mask >> step;

   //##############################
   // Control state
   //##############################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         mask <= '0;
         chan <= 2'b00;
      end
      else if (load)
      begin
         mask <= load_mask;     // New packet replaces last line
         chan <= load_chan;
      end
      else if (phy_ready)
      begin
         mask <= mask_next;     // Hold under back-pressure
      end
   end

   // Payload
   always_ff @(posedge clk)
   begin
      if (load)
         sreg <= load_pkt;
      else if (phy_ready)
         sreg <= sreg >> step_bits;
   end

   //##############################
   // Outputs
   //##############################

   assign free       = ~|mask | ~|mask_next;   // empty, or emptying now
   assign phy_txvld  = |mask;
   assign phy_txdata = sreg[`LUMI_IOW-1:0];
   assign line_taken = phy_txvld & phy_ready;
   assign line_chan  = chan;

endmodule

// File: lumi_tx_tb.sv
// Packets are sent one at a time per channel; line width only changes while the link is idle
`timescale 1ns/1ns
`include "lumi_defines.svh"

module lumi_tx_tb;

   localparam int N_PKT           = 54;                // packets over all phases
   localparam int WATCHDOG_CYCLES = N_PKT * 40 + 1000;

   logic                 clk;
   logic                 nreset = 1'b0;
   logic                 req_valid = 1'b0;
   lumi_pkg::umi_pkt_t   req_pkt = '0;
   logic                 req_ready;
   logic                 resp_valid = 1'b0;
   lumi_pkg::umi_pkt_t   resp_pkt = '0;
   logic                 resp_ready;
   logic                 reg_wr = 1'b0;
   logic [15:0]          reg_addr = '0;
   logic [15:0]          reg_wdata = '0;
   logic [15:0]          rmt_crdt_req = 16'hffff;    // plenty until the credit phase
   logic [15:0]          rmt_crdt_resp = 16'hffff;
   logic [15:0]          loc_crdt_req = 16'h1234;
   logic [15:0]          loc_crdt_resp = 16'h0abc;
   logic [63:0]          phy_txdata;
   logic                 phy_txvld;
   logic                 phy_ready = 1'b1;

   // Stimulus state
   logic [31:0]          rng = 32'h3be3_bfe1;
   logic [31:0]          bp_rng = 32'h3be3_bfe1;     // own stream for back-pressure
   logic                 bp_on = 1'b0;
   logic                 crdt_phase = 1'b0;          // credit messages may appear
   int                   iow = 0;                    // log2 bytes per line
   logic                 watch_first = 1'b0;
   logic                 first_chan;
   int                   accept_cnt = 0;

   // Expected packets in accept order
   lumi_pkg::umi_pkt_t   exp_pkt_q[$];
   logic                 exp_chan_q[$];              // 1 response, 0 request

   // Parser state
   logic [159:0]         got;
   int                   got_cnt;
   int                   remain = 0;                 // bytes left in current packet
   int                   line_cnt;
   logic                 cur_msg;
   lumi_pkg::umi_pkt_t   cur_pkt;
   logic                 cur_chan;
   int                   cur_bytes;
   int                   cur_lines;
   logic                 msg_half = 1'b0;            // resp msg seen, req msg due
   int                   msg_pairs = 0;
   int                   lines_req = 0;              // lines taken per channel
   int                   lines_resp = 0;
   int                   err_value = 0;
   int                   err_other = 0;

   lumi_tb_clock clock_i (.clk(clk));

   lumi_tx lumi_tx_i
     (.clk, .nreset,
      .req_valid, .req_pkt, .req_ready,
      .resp_valid, .resp_pkt, .resp_ready,
      .reg_wr, .reg_addr, .reg_wdata,
      .rmt_crdt_req, .rmt_crdt_resp, .loc_crdt_req, .loc_crdt_resp,
      .phy_txdata, .phy_txvld, .phy_ready);

   //##############################
   // Helpers
   //##############################

   function automatic logic [31:0] lcg(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Size rule from the command word alone
   function automatic void ref_size(input lumi_pkg::lumi_cmd_u cmd, input int width,
                                    output int bytes, output int lines);
      int data;
      data = (int'(cmd.umi.len) + 1) << cmd.umi.size;
      case (cmd.umi.opcode)
         `LUMI_OP_INVALID,
         `LUMI_OP_LINK:   bytes = 4;                    // Command only
         `LUMI_OP_READ,
         `LUMI_OP_WRRESP: bytes = 12;                   // Header only
         default:         bytes = 12 + ((data > 8) ? 8 : data);
      endcase
      lines = (bytes + (1 << width) - 1) >> width;     // round up
   endfunction

   task automatic check_value(input string name, input logic [159:0] got_val,
                              input logic [159:0] exp_val);
      if (got_val !== exp_val)
      begin
         err_value++;
         $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got_val, exp_val);
      end
   endtask

   // Random packet; op < 0 picks any opcode except LINK
   task automatic make_pkt(input int op, input logic full, output lumi_pkg::umi_pkt_t p);
      logic [159:0] raw;
      int           i;
      for (i = 0; i < 5; i++)
      begin
         rng = lcg(rng);
         raw[i * 32 +: 32] = rng;
      end
      p = raw;
      p.cmd.umi.opcode = (op < 0) ? raw[31:27] : 5'(op);
      if (op < 0 && p.cmd.umi.opcode == `LUMI_OP_LINK)
         p.cmd.umi.opcode = 5'd2;
      if (full)
      begin
         p.cmd.umi.len  = 8'd7;                         // 8 data bytes
         p.cmd.umi.size = 3'd0;
      end
   endtask

   task automatic reg_write(input logic [15:0] addr, input logic [15:0] data);
      reg_wr    = 1'b1;
      reg_addr  = addr;
      reg_wdata = data;
      @(posedge clk);
      #10;
      reg_wr    = 1'b0;
   endtask

   // Hold valid until ready seen before an edge
   task automatic send_pkt(input logic chan, input lumi_pkg::umi_pkt_t p);
      logic acc;
      if (chan)
      begin
         resp_pkt   = p;
         resp_valid = 1'b1;
      end
      else
      begin
         req_pkt   = p;
         req_valid = 1'b1;
      end
      acc = 1'b0;
      while (!acc)
      begin
         @(negedge clk);
         acc = chan ? resp_ready : req_ready;
         @(posedge clk);
      end
      #10;
      if (chan)
         resp_valid = 1'b0;
      else
         req_valid = 1'b0;
   endtask

   task automatic wait_idle();
      int quiet;
      quiet = 0;
      while (quiet < 3)
      begin
         @(negedge clk);
         if (exp_pkt_q.size() == 0 && remain == 0 && !phy_txvld)
            quiet++;
         else
            quiet = 0;
      end
      @(posedge clk);
      #10;
   endtask

   task automatic set_width(input int w);
      wait_idle();                                     // No packet in flight
      reg_write(`LUMI_REG_IOW, 16'(w));
      iow = w;
   endtask

   //##############################
   // Output parser
   //##############################

   task automatic finish_pkt();
      logic [159:0]        mask;
      lumi_pkg::lumi_cmd_u word;
      if (cur_msg)
      begin
         word = got[31:0];
         check_value("crdt.chan", 160'(word.crdt.chan), msg_half ? 160'd0 : 160'd1);
         check_value("crdt.credit", 160'(word.crdt.credit),
                     160'(msg_half ? loc_crdt_req : loc_crdt_resp));
         check_value("crdt.rsvd", 160'(word.crdt.rsvd), 160'd0);
         if (msg_half)
            msg_pairs++;
         msg_half = ~msg_half;
      end
      else
      begin
         mask = '1;
         mask = mask >> (160 - cur_bytes * 8);         // only the bytes sent
         check_value("phy packet", got & mask, cur_pkt & mask);
         check_value("line count", 160'(line_cnt), 160'(cur_lines));
      end
   endtask

   task automatic take_line();
      int step;
      int n;
      int i;
      step = 1 << iow;
      if (remain == 0)
      begin
         got      = '0;
         got_cnt  = 0;
         line_cnt = 0;
         if (crdt_phase && phy_txdata[7:0] == `LUMI_LINK_CODE)
         begin
            cur_msg = 1'b1;                            // credit message, cmd word only
            remain  = `LUMI_CW / 8;
         end
         else if (exp_pkt_q.size() == 0)
         begin
            err_other++;
            $display("Error at %0t ns: line on the phy while no packet was expected", $time);
            return;
         end
         else
         begin
            cur_msg  = 1'b0;
            cur_pkt  = exp_pkt_q.pop_front();
            cur_chan = exp_chan_q.pop_front();
            ref_size(cur_pkt.cmd, iow, cur_bytes, cur_lines);
            remain = cur_bytes;
            if (msg_half)
            begin
               err_other++;
               $display("Error at %0t ns: UMI packet inside a credit message pair", $time);
            end
         end
      end
      n = (step < remain) ? step : remain;
      for (i = 0; i < n; i++)
         got[(got_cnt + i) * 8 +: 8] = phy_txdata[i * 8 +: 8];
      got_cnt  += n;
      remain   -= n;
      line_cnt++;
      if (!cur_msg)
      begin
         if (cur_chan)
            lines_resp++;
         else
            lines_req++;
         if (cur_chan ? (lines_resp > int'(rmt_crdt_resp)) : (lines_req > int'(rmt_crdt_req)))
         begin
            err_other++;
            $display("Error at %0t ns: lines sent exceed the remote credit", $time);
         end
      end
      if (remain == 0)
         finish_pkt();
   endtask

   // Sample mid-cycle, transfers happen at the next edge
   always @(negedge clk)
   begin
      if (nreset)
      begin
         if (resp_valid && resp_ready)
         begin
            exp_pkt_q.push_back(resp_pkt);
            exp_chan_q.push_back(1'b1);
         end
         if (req_valid && req_ready)
         begin
            exp_pkt_q.push_back(req_pkt);
            exp_chan_q.push_back(1'b0);
         end
         if ((req_valid && req_ready) || (resp_valid && resp_ready))
         begin
            accept_cnt++;
            if (watch_first)
            begin
               first_chan  = resp_valid && resp_ready;
               watch_first = 1'b0;
            end
         end
         if (phy_txvld && phy_ready)
            take_line();
      end
   end

   // Random back-pressure, about half the cycles
   always @(posedge clk)
   begin
      #10;
      if (bp_on)
      begin
         bp_rng    = lcg(bp_rng);
         phy_ready = bp_rng[31];
      end
      else
         phy_ready = 1'b1;
   end

   initial
   begin
      #(WATCHDOG_CYCLES * 100);
      $display("Error: timeout, run did not end within %0d cycles", WATCHDOG_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
   end

   //##############################
   // Test sequence
   //##############################

   initial
   begin
      lumi_pkg::umi_pkt_t p;
      lumi_pkg::umi_pkt_t q;
      int                 w;
      int                 n;
      repeat (16) @(posedge clk);
      #10;
      nreset = 1'b1;
      reg_write(`LUMI_REG_CTRL, 16'h0001);             // en only

      // Data class at every width
      for (w = 0; w < 4; w++)
      begin
         set_width(w);
         for (n = 0; n < 4; n++)
         begin
            make_pkt(8 + n, 1'b0, p);
            send_pkt(n[0], p);                         // back to back
         end
      end

      // Command-only and header-only classes
      for (w = 0; w < 4; w += 3)
      begin
         set_width(w);
         for (n = 0; n < 4; n++)
         begin
            make_pkt((n == 0) ? 0 : (n == 1) ? 15 : (n == 2) ? 1 : 4, 1'b1, p);
            send_pkt(n[0], p);
         end
      end

      // Both channels at once, response wins
      for (n = 0; n < 2; n++)
      begin
         wait_idle();
         make_pkt(-1, 1'b0, p);
         make_pkt(-1, 1'b0, q);
         watch_first = 1'b1;
         fork
            send_pkt(1'b1, p);
            send_pkt(1'b0, q);
         join
         if (first_chan !== 1'b1)
         begin
            err_other++;
            $display("Error at %0t ns: request accepted ahead of a waiting response", $time);
         end
      end

      // Back-pressure on a 2-byte line
      set_width(1);
      bp_on = 1'b1;
      for (n = 0; n < 12; n++)
      begin
         make_pkt(-1, 1'b0, p);
         send_pkt(n[0], p);
      end
      wait_idle();
      bp_on = 1'b0;

      // Small remote credit on request, 20 lines per packet
      set_width(0);
      rmt_crdt_req = 16'(lines_req + 30);
      make_pkt(8, 1'b1, p);
      send_pkt(1'b0, p);
      wait_idle();
      make_pkt(9, 1'b1, p);                            // needs 20, only 10 left
      n = accept_cnt;
      fork
         send_pkt(1'b0, p);
         begin
            repeat (30) @(posedge clk);
            #10;
            if (accept_cnt != n)
            begin
               err_other++;
               $display("Error at %0t ns: request started without enough credit", $time);
            end
            rmt_crdt_req = 16'(lines_req + 40);        // Releases the held packet
         end
      join
      wait_idle();
      rmt_crdt_req = 16'hffff;

      // Credit update messages with traffic
      set_width(2);
      crdt_phase = 1'b1;
      reg_write(`LUMI_REG_INTRVL, 16'd20);
      reg_write(`LUMI_REG_CTRL, 16'h0003);             // en and crdt_en
      for (n = 0; n < 12; n++)
      begin
         make_pkt(-1, 1'b0, p);
         send_pkt(n[0], p);
      end
      repeat (60) @(posedge clk);                      // a few intervals
      wait_idle();
      if (msg_pairs < 2 || msg_half)
      begin
         err_other++;
         $display("Error: credit messages missing or a pair left incomplete (%0d pairs)",
                  msg_pairs);
      end

      $display("Errors: %0d wrong values, %0d other failures", err_value, err_other);
      if (err_value == 0 && err_other == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// File: run.sh
#!/bin/sh
# Compile and run the lumi_tx testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
   -f sources.f \
   --top-module lumi_tx_tb \
   -Mdir obj_dir

out=$(./obj_dir/Vlumi_tx_tb)
echo "$out"

if echo "$out" | grep -q "Simulation finished: PASS"; then
   exit 0
else
   exit 1
fi

// File: sources.f
+incdir+.
lumi_pkg.sv
lumi_tx_regs.sv
lumi_pkt_sizer.sv
lumi_credit_ctrl.sv
lumi_tx_arbiter.sv
lumi_tx_shifter.sv
lumi_tx.sv
lumi_tb_clock.sv
lumi_tx_tb.sv
